/* files.f */
verilog/aux_pkg.sv
verilog/aux_wb_regs.sv
verilog/aux_tx_fifo.sv
verilog/aux_manchester_tx.sv
verilog/aux_tx_top.sv
verification/aux_tx_props.sv
verification/tb_aux_tx.sv

/* Makefile */
# Verilator build, run and lint for the AUX transmit testbench
# Any variable can be overridden, for example: make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_aux_tx
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# A run that aborts or never reports success is logged as a failure
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@if grep -q "%Error" $(LOG) || ! grep -q ">>> PASS" $(LOG); then echo ">>> FAIL" >> $(LOG); fi
	@cat $(LOG)
	@! grep -q ">>> FAIL" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/tb_aux_tx.sv */
// Testbench for the AUX channel transmit top level
// Clock, reset and beat generation with mid half-period line sampling
// LCG random stimulus, Wishbone read and write tasks
// Line decoder model built from the written tokens
// Register, FIFO, interrupt and abort checks
`timescale 1ns/1ps

module tb_aux_tx;

	localparam int          CLK_HALF = 20;    // 40 ns period
	localparam int          BUS_TMO  = 20;    // Clocks to wait for ack
	localparam int          DONE_TMO = 2000;  // Status polls per message
	localparam logic [31:0] RUN_B    = 32'd1 << aux_pkg::CTL_RUN;
	localparam logic [31:0] IE_B     = 32'd1 << aux_pkg::CTL_IE;
	localparam logic [31:0] SEND_B   = 32'd1 << aux_pkg::CTL_SEND;

	logic                          CLK_IN;
	logic                          RST_IN;
	logic                          wb_cyc;
	logic                          wb_stb;
	logic                          wb_we;
	logic [1:0]                    wb_adr;
	logic [aux_pkg::WB_DAT_W-1:0]  wb_dat_w;
	logic [aux_pkg::WB_DAT_W-1:0]  wb_dat_r;
	logic                          wb_ack;
	logic                          beat;
	logic                          aux_en;
	logic                          aux_tx;
	logic                          irq;

	logic [31:0]  rng_state;
	int           beat_cnt;
	int           errors;
	int           timeouts;
	int           checks;
	logic         halves [$];      // Line half-levels seen while enabled
	logic         expect_q [$];    // Half-levels from the decoder model

	aux_tx_top UUT
	(
		.CLK_IN(CLK_IN), .RST_IN(RST_IN),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.beat(beat), .aux_en(aux_en), .aux_tx(aux_tx), .irq(irq)
	);

	initial
	begin
		CLK_IN = 1'b0;
		forever #CLK_HALF CLK_IN = ~CLK_IN;
	end

	// Beat toggles every 8 clocks, line sampled 4 clocks into each half
	initial
	begin
		beat     = 1'b0;
		beat_cnt = 0;
		forever
		begin
			@(posedge CLK_IN);
			#2;
			if (beat_cnt == 7)
			begin
				beat     = ~beat;
				beat_cnt = 0;
			end
			else
				beat_cnt = beat_cnt + 1;
			if (beat_cnt == 4 && aux_en)
				halves.push_back(aux_tx);
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {16'd0, rng_state[31:16]};    // Upper bits have the longer period
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		if (act_v !== exp_v)
		begin
			errors++;
			$display("FAIL %s expected %0h actual %0h", name, exp_v, act_v);
		end
	endtask

	// Open a bus cycle and wait for the single ack
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
		output logic [31:0] rdat);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		n = 0;
		do
		begin
			@(posedge CLK_IN);    // Ack of a previous cycle drops first
			#2;
			n++;
		end
		while (!wb_ack && n < BUS_TMO);
		if (!wb_ack)
		begin
			timeouts++;
			$display("Timeout: no wb_ack for access to address %0d", adr);
		end
		rdat   = wb_dat_r;    // Valid while ack is high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'd0, dat);
	endtask

	// Token write plus its expected half-levels
	task automatic queue_token(input logic [8:0] tok);
		write_reg(aux_pkg::ADR_TXF, {23'd0, tok});
		if (tok[aux_pkg::TOK_STOP])
		begin
			repeat (4) expect_q.push_back(1'b1);    // Two beats high
			repeat (4) expect_q.push_back(1'b0);    // Two beats low
		end
		else
		begin
			for (int i = 7; i >= 0; i--)
			begin
				expect_q.push_back(tok[i]);     // MSB first
				expect_q.push_back(!tok[i]);
			end
		end
	endtask

	task automatic wait_done();
		logic [31:0] sta;
		int          n;
		sta = '0;
		n   = 0;
		while (!sta[aux_pkg::STA_DONE] && n < DONE_TMO)
		begin
			read_reg(aux_pkg::ADR_STA, sta);
			n++;
		end
		if (!sta[aux_pkg::STA_DONE])
		begin
			timeouts++;
			$display("Timeout: message done flag never set");
		end
	endtask

	// Stop, random data bytes, stop; then compare the line
	task automatic send_message(input logic [31:0] ctl, input int nbytes, input string name);
		logic [31:0] r;
		logic [31:0] rd;
		expect_q.delete();
		halves.delete();
		expect_q.push_back(1'b0);    // Low half before first token
		queue_token(9'h100);
		for (int k = 0; k < nbytes; k++)
		begin
			r = next_rand();
			queue_token({1'b0, r[7:0]});
		end
		queue_token(9'h100);
		write_reg(aux_pkg::ADR_CTL, ctl | SEND_B);
		wait_done();
		checks++;
		if (halves.size() < expect_q.size())
		begin
			errors++;
			$display("FAIL %s half-levels expected %0d actual %0d", name,
				expect_q.size(), halves.size());
		end
		else
		begin
			for (int i = 0; i < expect_q.size(); i++)
			begin
				if (halves[i] !== expect_q[i])
				begin
					errors++;
					$display("FAIL %s half %0d expected %b actual %b", name, i,
						expect_q[i], halves[i]);
				end
			end
		end
		read_reg(aux_pkg::ADR_CTL, rd);
		check_val({name, " send cleared"}, ctl, rd);
	endtask

	initial
	begin
		logic [31:0] rd;
		logic [31:0] r;
		int          n;
		int          bad;
		rng_state = 32'hda58;
		errors    = 0;
		timeouts  = 0;
		checks    = 0;
		RST_IN    = 1'b1;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = 2'd0;
		wb_dat_w  = '0;
		repeat (2) @(posedge CLK_IN);
		#2;
		RST_IN = 1'b0;

		// Reset values and control readback
		read_reg(aux_pkg::ADR_CTL, rd);
		check_val("reset ctl", 32'd0, rd);
		check_val("reset irq", 32'd0, 32'(irq));
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("reset status", 32'd1 << aux_pkg::STA_EP, rd);
		write_reg(aux_pkg::ADR_CTL, RUN_B | IE_B);
		read_reg(aux_pkg::ADR_CTL, rd);
		check_val("ctl readback", RUN_B | IE_B, rd);

		// FIFO fill, full and overflow
		n = int'(next_rand() % 32'd31) + 1;
		for (int k = 0; k < n; k++)
		begin
			r = next_rand();
			write_reg(aux_pkg::ADR_TXF, {23'd0, r[8:0]});
		end
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("fill count", 32'(n), 32'(rd[aux_pkg::STA_WRDS +: 6]));
		check_val("fill empty", 32'd0, 32'(rd[aux_pkg::STA_EP]));
		for (int k = n; k < aux_pkg::FIFO_WRDS; k++)
			write_reg(aux_pkg::ADR_TXF, 32'h055);
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("full count", 32'd32, 32'(rd[aux_pkg::STA_WRDS +: 6]));
		check_val("full flag", 32'd1, 32'(rd[aux_pkg::STA_FL]));
		write_reg(aux_pkg::ADR_TXF, 32'h0aa);    // Dropped
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("overflow count", 32'd32, 32'(rd[aux_pkg::STA_WRDS +: 6]));
		write_reg(aux_pkg::ADR_CTL, 32'd0);      // Flush
		write_reg(aux_pkg::ADR_CTL, RUN_B | IE_B);
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("flush count", 32'd0, 32'(rd[aux_pkg::STA_WRDS +: 6]));

		// Message with interrupt enabled, then flag clearing
		send_message(RUN_B | IE_B, int'(next_rand() % 32'd6) + 1, "message ie");
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("ie done bit", 32'd1, 32'(rd[aux_pkg::STA_DONE]));
		check_val("ie irq bit", 32'd1, 32'(rd[aux_pkg::STA_IRQ]));
		check_val("ie irq pin", 32'd1, 32'(irq));
		write_reg(aux_pkg::ADR_STA, 32'd1 << aux_pkg::STA_DONE);
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("done cleared", 32'd0, 32'(rd[aux_pkg::STA_DONE]));
		check_val("irq kept", 32'd1, 32'(rd[aux_pkg::STA_IRQ]));
		write_reg(aux_pkg::ADR_STA, 32'd1 << aux_pkg::STA_IRQ);
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("irq cleared", 32'd0, 32'(rd[aux_pkg::STA_IRQ]));
		check_val("irq pin cleared", 32'd0, 32'(irq));

		// Message with interrupt disabled
		send_message(RUN_B, int'(next_rand() % 32'd6) + 1, "message no ie");
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("no ie done bit", 32'd1, 32'(rd[aux_pkg::STA_DONE]));
		check_val("no ie irq bit", 32'd0, 32'(rd[aux_pkg::STA_IRQ]));
		check_val("no ie irq pin", 32'd0, 32'(irq));

		// Run cleared with tokens queued
		for (int k = 0; k < 4; k++)
		begin
			r = next_rand();
			write_reg(aux_pkg::ADR_TXF, {24'd0, r[7:0]});
		end
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("queued count", 32'd4, 32'(rd[aux_pkg::STA_WRDS +: 6]));
		write_reg(aux_pkg::ADR_CTL, 32'd0);
		read_reg(aux_pkg::ADR_STA, rd);
		check_val("stopped count", 32'd0, 32'(rd[aux_pkg::STA_WRDS +: 6]));
		write_reg(aux_pkg::ADR_CTL, SEND_B);    // Send without run
		bad = 0;
		repeat (48)    // Three beat periods
		begin
			@(posedge CLK_IN);
			#2;
			if (aux_en || aux_tx)
				bad++;
		end
		check_val("stopped line", 32'd0, 32'(bad));

		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* verification/aux_tx_props.sv */
// Concurrent assertions for the AUX transmit top level
// Single clock bus ack, idle line while stopped, FIFO flag sanity
`timescale 1ns/1ps

module aux_tx_props
(
	input logic CLK_IN,
	input logic RST_IN,
	input logic wb_ack,
	input logic run,      // CTL_RUN bit
	input logic aux_en,
	input logic aux_tx,
	input logic ep,
	input logic fl
);

	// Ack never held for two clocks
	ack_single : assert property (@(posedge CLK_IN) disable iff (RST_IN) wb_ack |=> !wb_ack)
		else $error("wb_ack high on two consecutive clocks");

	// Line outputs registered, released one clock after run is seen low
	line_idle : assert property (@(posedge CLK_IN) disable iff (RST_IN)
		!run |=> (!aux_en && !aux_tx))
		else $error("aux_en or aux_tx high while run is low");

	flags_excl : assert property (@(posedge CLK_IN) disable iff (RST_IN) !(ep && fl))
		else $error("FIFO empty and full flags high together");

endmodule

bind aux_tx_top aux_tx_props u_props
(
	.CLK_IN(CLK_IN), .RST_IN(RST_IN), .wb_ack(wb_ack), .run(run),
	.aux_en(aux_en), .aux_tx(aux_tx), .ep(ep), .fl(fl)
);

/* verilog/aux_tx_top.sv */
// AUX channel transmitter top level
// Wishbone register block, token FIFO and Manchester encoder
`timescale 1ns/1ps

module aux_tx_top
(
	input  logic                          CLK_IN,
	input  logic                          RST_IN,
	input  logic                          wb_cyc,
	input  logic                          wb_stb,
	input  logic                          wb_we,
	input  logic [1:0]                    wb_adr,
	input  logic [aux_pkg::WB_DAT_W-1:0]  wb_dat_w,
	output logic [aux_pkg::WB_DAT_W-1:0]  wb_dat_r,
	output logic                          wb_ack,
	input  logic                          beat,       // Bit timing reference
	output logic                          aux_en,
	output logic                          aux_tx,
	output logic                          irq
);

	logic                        run;
	logic                        send;
	logic                        fifo_wr;
	aux_pkg::token_t             fifo_din;
	logic                        fifo_rd;
	aux_pkg::token_t             head;
	logic                        head_vld;
	logic [aux_pkg::FIFO_ADR:0]  wrds;
	logic                        ep;
	logic                        fl;
	logic                        msg_start;
	logic                        msg_done;

	aux_wb_regs u_regs
	(
		.CLK_IN(CLK_IN), .RST_IN(RST_IN),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.msg_start(msg_start), .msg_done(msg_done),
		.wrds(wrds), .ep(ep), .fl(fl),
		.run(run), .send(send), .fifo_wr(fifo_wr), .fifo_din(fifo_din), .irq(irq)
	);

	aux_tx_fifo u_fifo
	(
		.CLK_IN(CLK_IN), .RST_IN(RST_IN), .run(run),
		.wr(fifo_wr), .din(fifo_din), .rd(fifo_rd),
		.head(head), .head_vld(head_vld), .wrds(wrds), .ep(ep), .fl(fl)
	);

	aux_manchester_tx u_enc
	(
		.CLK_IN(CLK_IN), .RST_IN(RST_IN), .run(run), .beat(beat), .send(send),
		.head(head), .head_vld(head_vld), .fifo_rd(fifo_rd),
		.msg_start(msg_start), .msg_done(msg_done), .aux_en(aux_en), .aux_tx(aux_tx)
	);

endmodule

/* verilog/aux_manchester_tx.sv */
// AUX Manchester transmitter
// Beat edge detection (registered rise and fall pulses)
// Token fetch from FIFO, 8 bit shifter with bit counter
// FSM for data bits, stop pattern and message framing
// Line enable and line level registers
`timescale 1ns/1ps

module aux_manchester_tx
(
	input  logic             CLK_IN,
	input  logic             RST_IN,
	input  logic             run,
	input  logic             beat,
	input  logic             send,
	input  aux_pkg::token_t  head,
	input  logic             head_vld,
	output logic             fifo_rd,
	output logic             msg_start,
	output logic             msg_done,
	output logic             aux_en,
	output logic             aux_tx
);

	aux_pkg::tx_state_t  st_cur;
	aux_pkg::tx_state_t  st_nxt;
	logic                beat_q;
	logic                beat_re;
	logic                beat_fe;
	logic [7:0]          shft;
	logic [2:0]          bit_cnt;
	logic                shft_ld;
	logic                shft_nxt;
	logic                en_set;
	logic                en_clr;
	logic                tx_set;
	logic                tx_clr;

	// Beat edges, one clock behind the input
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
		begin
			beat_q  <= 1'b0;
			beat_re <= 1'b0;
			beat_fe <= 1'b0;
		end
		else
		begin
			beat_q  <= beat;
			beat_re <= beat && !beat_q;
			beat_fe <= !beat && beat_q;
		end
	end

	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			st_cur <= aux_pkg::tx_idle;
		else if (!run)
			st_cur <= aux_pkg::tx_idle;    // Abort
		else
			st_cur <= st_nxt;
	end

	// Next state and strobes
	always_comb
	begin
		st_nxt    = st_cur;
		fifo_rd   = 1'b0;
		msg_start = 1'b0;
		msg_done  = 1'b0;
		shft_ld   = 1'b0;
		shft_nxt  = 1'b0;
		en_set    = 1'b0;
		en_clr    = 1'b0;
		tx_set    = 1'b0;
		tx_clr    = 1'b0;
		case (st_cur)
			aux_pkg::tx_idle :
			begin
				if (run && send)
				begin
					msg_start = 1'b1;
					st_nxt    = aux_pkg::tx_enable;
				end
			end
			aux_pkg::tx_enable :
			begin
				if (beat_fe)
				begin
					en_set = 1'b1;    // Line starts low for half a beat
					st_nxt = aux_pkg::tx_load;
				end
			end
			aux_pkg::tx_load :
			begin
				if (head_vld)
				begin
					fifo_rd = 1'b1;
					if (head.stop)
						st_nxt = aux_pkg::tx_stop1;
					else
					begin
						shft_ld = 1'b1;
						st_nxt  = aux_pkg::tx_rise;
					end
				end
				else if (beat_re)
				begin
					en_clr   = 1'b1;    // FIFO drained, end of message
					msg_done = 1'b1;
					st_nxt   = aux_pkg::tx_idle;
				end
			end
			aux_pkg::tx_rise :
			begin
				if (beat_re)
				begin
					tx_set = shft[7];     // First half is the bit value
					tx_clr = !shft[7];
					st_nxt = aux_pkg::tx_fall;
				end
			end
			aux_pkg::tx_fall :
			begin
				if (beat_fe)
				begin
					tx_set = !shft[7];    // Second half inverted
					tx_clr = shft[7];
					if (bit_cnt == 3'd0)
						st_nxt = aux_pkg::tx_load;
					else
					begin
						shft_nxt = 1'b1;
						st_nxt   = aux_pkg::tx_rise;
					end
				end
			end
			aux_pkg::tx_stop1 :
			begin
				if (beat_re)
				begin
					tx_set = 1'b1;
					st_nxt = aux_pkg::tx_stop2;
				end
			end
			aux_pkg::tx_stop2 : if (beat_re) st_nxt = aux_pkg::tx_stop3;
			aux_pkg::tx_stop3 :
			begin
				if (beat_re)
				begin
					tx_clr = 1'b1;    // Two beats high done
					st_nxt = aux_pkg::tx_stop4;
				end
			end
			aux_pkg::tx_stop4 : if (beat_re) st_nxt = aux_pkg::tx_load;
			default : st_nxt = aux_pkg::tx_idle;
		endcase
	end

	// Shifter, MSB first
	always_ff @(posedge CLK_IN)
	begin
		if (shft_ld)
		begin
			shft    <= head.data;
			bit_cnt <= 3'd7;
		end
		else if (shft_nxt)
		begin
			shft    <= {shft[6:0], 1'b0};
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// Line outputs
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
		begin
			aux_en <= 1'b0;
			aux_tx <= 1'b0;
		end
		else if (!run)
		begin
			aux_en <= 1'b0;
			aux_tx <= 1'b0;
		end
		else
		begin
			if (en_set)
				aux_en <= 1'b1;
			else if (en_clr)
				aux_en <= 1'b0;
			if (tx_set)
				aux_tx <= 1'b1;
			else if (tx_clr)
				aux_tx <= 1'b0;
		end
	end

endmodule

/* verilog/aux_tx_fifo.sv */
// AUX transmit token FIFO
// Circular buffer, first word fall through head
// Word count, empty and full flags
// Flushed while run is low
`timescale 1ns/1ps

module aux_tx_fifo
(
	input  logic                        CLK_IN,
	input  logic                        RST_IN,
	input  logic                        run,
	input  logic                        wr,
	input  aux_pkg::token_t             din,
	input  logic                        rd,
	output aux_pkg::token_t             head,       // Oldest token
	output logic                        head_vld,
	output logic [aux_pkg::FIFO_ADR:0]  wrds,
	output logic                        ep,
	output logic                        fl
);

	aux_pkg::token_t                mem [aux_pkg::FIFO_WRDS];
	logic [aux_pkg::FIFO_ADR-1:0]   wp;
	logic [aux_pkg::FIFO_ADR-1:0]   rp;
	logic [aux_pkg::FIFO_ADR:0]     cnt;
	logic                           wr_ok;
	logic                           rd_ok;

	assign wr_ok = run && wr && !fl;    // Write while full is dropped
	assign rd_ok = run && rd && !ep;

	// Storage
	always_ff @(posedge CLK_IN)
	begin
		if (wr_ok)
			mem[wp] <= din;
	end

	// Pointers and count
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
		begin
			wp  <= '0;
			rp  <= '0;
			cnt <= '0;
		end
		else if (!run)
		begin
			wp  <= '0;    // Flush
			rp  <= '0;
			cnt <= '0;
		end
		else
		begin
			if (wr_ok)
				wp <= wp + 1'b1;
			if (rd_ok)
				rp <= rp + 1'b1;
			if (wr_ok && !rd_ok)
				cnt <= cnt + 1'b1;
			else if (rd_ok && !wr_ok)
				cnt <= cnt - 1'b1;
		end
	end

	assign ep       = (cnt == '0);
	assign fl       = cnt[aux_pkg::FIFO_ADR];    // MSB only set at full depth
	assign wrds     = cnt;
	assign head     = mem[rp];
	assign head_vld = !ep;

endmodule

/* verilog/aux_wb_regs.sv */
// AUX transmit register block
// Wishbone classic slave with single cycle registered ack
// Control register with self clearing send bit
// Status word with done and irq flags (write one to clear)
// TX FIFO write strobe and token
`timescale 1ns/1ps

module aux_wb_regs
(
	input  logic                           CLK_IN,
	input  logic                           RST_IN,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [1:0]                     wb_adr,
	input  logic [aux_pkg::WB_DAT_W-1:0]   wb_dat_w,
	output logic [aux_pkg::WB_DAT_W-1:0]   wb_dat_r,
	output logic                           wb_ack,
	input  logic                           msg_start,    // Encoder took the send request
	input  logic                           msg_done,     // Encoder finished a message
	input  logic [aux_pkg::FIFO_ADR:0]     wrds,
	input  logic                           ep,
	input  logic                           fl,
	output logic                           run,
	output logic                           send,
	output logic                           fifo_wr,
	output aux_pkg::token_t                fifo_din,
	output logic                           irq
);

	logic                           bus_act;    // Cycle open and not yet acked
	logic                           bus_wr;
	logic                           sta_wr;     // Status write, clears flags
	logic                           ie;
	logic                           done;
	logic [aux_pkg::CTL_WIDTH-1:0]  ctl_r;
	logic [aux_pkg::STA_WIDTH-1:0]  sta_r;
	logic [aux_pkg::WB_DAT_W-1:0]   rd_mux;

	assign bus_act = wb_cyc && wb_stb && !wb_ack;    // Blocks back to back acks
	assign bus_wr  = bus_act && wb_we;
	assign sta_wr  = bus_wr && (wb_adr == aux_pkg::ADR_STA);

	// Ack one clock after the cycle opens
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			wb_ack <= 1'b0;
		else
			wb_ack <= bus_act;
	end

	// Control register
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
			ctl_r <= '0;
		else if (bus_wr && (wb_adr == aux_pkg::ADR_CTL))
			ctl_r <= wb_dat_w[aux_pkg::CTL_WIDTH-1:0];
		else if (msg_start)
			ctl_r[aux_pkg::CTL_SEND] <= 1'b0;    // Request taken
	end

	assign run  = ctl_r[aux_pkg::CTL_RUN];
	assign ie   = ctl_r[aux_pkg::CTL_IE];
	assign send = ctl_r[aux_pkg::CTL_SEND];

	// Message done flag and interrupt, both dropped when not running
	always_ff @(posedge CLK_IN or posedge RST_IN)
	begin
		if (RST_IN)
		begin
			done <= 1'b0;
			irq  <= 1'b0;
		end
		else if (!run)
		begin
			done <= 1'b0;
			irq  <= 1'b0;
		end
		else
		begin
			if (msg_done)
				done <= 1'b1;
			else if (sta_wr && wb_dat_w[aux_pkg::STA_DONE])
				done <= 1'b0;

			if (msg_done && ie)
				irq <= 1'b1;    // Only with interrupts enabled
			else if (sta_wr && wb_dat_w[aux_pkg::STA_IRQ])
				irq <= 1'b0;
		end
	end

	// Status word
	always_comb
	begin
		sta_r = '0;
		sta_r[aux_pkg::STA_IRQ]  = irq;
		sta_r[aux_pkg::STA_DONE] = done;
		sta_r[aux_pkg::STA_EP]   = ep;
		sta_r[aux_pkg::STA_FL]   = fl;
		sta_r[aux_pkg::STA_WRDS +: aux_pkg::FIFO_ADR+1] = wrds;
	end

	// Read mux, FIFO port and address 3 read as zero
	always_comb
	begin
		rd_mux = '0;
		case (wb_adr)
			aux_pkg::ADR_CTL : rd_mux[aux_pkg::CTL_WIDTH-1:0] = ctl_r;
			aux_pkg::ADR_STA : rd_mux[aux_pkg::STA_WIDTH-1:0] = sta_r;
			default          : ;
		endcase
	end

	// Read data lines up with ack
	always_ff @(posedge CLK_IN)
	begin
		if (bus_act && !wb_we)
			wb_dat_r <= rd_mux;
		else
			wb_dat_r <= '0;
	end

	// FIFO write lands on the ack edge
	assign fifo_wr  = bus_wr && (wb_adr == aux_pkg::ADR_TXF);
	assign fifo_din = aux_pkg::token_t'(wb_dat_w[aux_pkg::TOK_W-1:0]);

endmodule

/* verilog/aux_pkg.sv */
// AUX channel transmit package
// Register word addresses and control/status bit positions
// Bus width and transmit FIFO sizes
// Token layout (data byte plus stop flag)
// Encoder FSM state encoding
package aux_pkg;

	// Register word addresses
	localparam logic [1:0] ADR_CTL = 2'd0;    // Control
	localparam logic [1:0] ADR_STA = 2'd1;    // Status
	localparam logic [1:0] ADR_TXF = 2'd2;    // TX FIFO write port

	// Control register bits
	localparam int CTL_RUN   = 0;    // Run
	localparam int CTL_IE    = 1;    // Interrupt enable
	localparam int CTL_SEND  = 2;    // Send message, self clearing
	localparam int CTL_WIDTH = 3;

	// Status register bits
	localparam int STA_IRQ   = 0;    // Interrupt pending
	localparam int STA_DONE  = 1;    // Message done
	localparam int STA_EP    = 2;    // FIFO empty
	localparam int STA_FL    = 3;    // FIFO full
	localparam int STA_WRDS  = 4;    // Word count, 6 bits wide
	localparam int STA_WIDTH = 10;

	// Sizes
	localparam int FIFO_WRDS = 32;
	localparam int FIFO_ADR  = 5;
	localparam int WB_DAT_W  = 32;

	// Token layout
	localparam int TOK_STOP = 8;    // Stop flag position
	localparam int TOK_W    = 9;

	typedef struct packed {
		logic       stop;    // Stop token, data ignored
		logic [7:0] data;
	} token_t;

	// Encoder states
	typedef enum logic [3:0] {
		tx_idle, tx_enable, tx_load, tx_rise, tx_fall,
		tx_stop1, tx_stop2, tx_stop3, tx_stop4
	} tx_state_t;

endpackage
